// File: fetch_pkg.sv
package fetch_pkg;

    localparam int ISA_WIDTH = 32;                      // instruction and data word width
    localparam int ROM_DEPTH = 10;                      // imem word address bits
    localparam int ROM_WORDS = 1 << ROM_DEPTH;          // 1024 words of program space

    typedef logic [ISA_WIDTH - 1:0] word_t;             // one instruction or data word
    typedef logic [ROM_DEPTH - 1:0] rom_addr_t;         // imem word address
    typedef logic [ROM_DEPTH:0]     load_addr_t;        // msb picks imem or dmem half
    typedef word_t                  pc_t;               // byte address

    // loader / hazard FSM
    typedef enum logic [1:0] {
        LD_RUN     = 2'b00,                             // normal fetch
        LD_LOAD    = 2'b01,                             // programmer is streaming words
        LD_RESTART = 2'b10                              // one cycle, pc forced to zero
    } load_state_t;

    localparam pc_t   PC_STEP        = pc_t'(4);        // bytes per instruction
    localparam pc_t   PC_RESET_VALUE = '0;              // boot and restart address
    localparam word_t NOP_WORD       = '0;              // shown to decode during a bubble

endpackage

// File: imem_write_if.sv
`timescale 1ns/1ps

interface imem_write_if;

    logic               wen;                            // lower-half load write strobe
    fetch_pkg::rom_addr_t addr;                         // word address inside imem
    fetch_pkg::word_t   data;                           // word to store
    logic               busy;                           // loader FSM out of LD_RUN

    // loader side drives everything, no back-pressure
    modport loader (
        output wen,
        output addr,
        output data,
        output busy
    );

    // memory side only listens
    modport mem (
        input  wen,
        input  addr,
        input  data,
        input  busy
    );

endinterface

// File: instruction_rom.sv
`timescale 1ns/1ps

module instruction_rom (
    input  logic                 clk,
    input  logic                 rd_en,                 // fetch read strobe
    input  fetch_pkg::rom_addr_t rd_addr,               // word address from pc
    imem_write_if.mem            wr,                    // load writes from the loader
    output fetch_pkg::word_t     rd_data                // registered read word
);

    fetch_pkg::word_t mem [fetch_pkg::ROM_WORDS];       // program storage

    logic wr_fire;                                      // write accepted this cycle

    // writes only count while the FSM says a load is running
    assign wr_fire = wr.wen & wr.busy;

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr.addr] <= wr.data;                    // load word lands on this edge
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];                    // one cycle read latency
        end
    end

endmodule

// File: instruction_fetch.sv
`timescale 1ns/1ps

module instruction_fetch (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              hold,                     // keep pc this cycle
    input  logic              no_op,                    // insert a bubble
    input  logic              pc_restart,               // jump back to zero after load

    input  logic              pc_offset,                // relative branch taken
    input  fetch_pkg::word_t  pc_offset_value,          // offset in instructions
    input  logic              pc_overload,              // absolute jump taken
    input  fetch_pkg::pc_t    pc_overload_value,        // jump target in bytes

    imem_write_if.mem         wr,                       // load path into imem

    output fetch_pkg::pc_t    pc,                       // current fetch address
    output fetch_pkg::pc_t    id_pc,                    // pc of the word now at decode
    output fetch_pkg::word_t  instruction,              // word handed to decode
    output logic              if_no_op                  // bubble flag for decode
);

    fetch_pkg::pc_t       pc_next;                      // selected next address
    fetch_pkg::word_t     rom_data;                     // raw memory output
    fetch_pkg::rom_addr_t rom_addr;                     // word index of pc
    logic                 rom_rd_en;

    assign rom_addr  = pc[fetch_pkg::ROM_DEPTH + 1:2];  // pc counts bytes, imem counts words
    assign rom_rd_en = ~wr.busy;                        // no fetch while the loader owns imem

    instruction_rom u_rom (
        .clk     (clk),
        .rd_en   (rom_rd_en),
        .rd_addr (rom_addr),
        .wr      (wr),
        .rd_data (rom_data)
    );

    // restart beats overload beats offset beats sequential
    always_comb begin
        if (pc_restart) begin
            pc_next = fetch_pkg::PC_RESET_VALUE;
        end else if (pc_overload) begin
            pc_next = pc_overload_value;
        end else if (pc_offset) begin
            pc_next = pc + pc_offset_value * fetch_pkg::PC_STEP;    // offset counts words
        end else begin
            pc_next = pc + fetch_pkg::PC_STEP;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= fetch_pkg::PC_RESET_VALUE;
            id_pc    <= fetch_pkg::PC_RESET_VALUE;
            if_no_op <= 1'b0;
        end else begin
            if (!hold) begin
                pc <= pc_next;                          // frozen on stall or load
            end
            id_pc    <= pc;                             // lines up with rom_data
            if_no_op <= no_op;                          // one cycle behind, like the rom read
        end
    end

    // bubble hides whatever the rom last produced
    assign instruction = if_no_op ? fetch_pkg::NOP_WORD : rom_data;

endmodule

// File: program_loader.sv
`timescale 1ns/1ps

module program_loader (
    input  logic                  uart_wen,             // one word per cycle
    input  fetch_pkg::load_addr_t uart_addr,            // msb selects the half
    input  fetch_pkg::word_t      uart_data,
    input  logic                  busy,                 // from hazard ctrl

    imem_write_if.loader          wr,                   // lower half to imem

    output logic                  dmem_wen,             // upper half leaves the design
    output fetch_pkg::rom_addr_t  dmem_addr,
    output fetch_pkg::word_t      dmem_data
);

    logic                 upper_half;                   // address msb
    fetch_pkg::rom_addr_t word_addr;                    // address without the half bit

    assign upper_half = uart_addr[fetch_pkg::ROM_DEPTH];
    assign word_addr  = uart_addr[fetch_pkg::ROM_DEPTH - 1:0];

    // instruction half
    assign wr.wen  = uart_wen & ~upper_half;
    assign wr.addr = word_addr;
    assign wr.data = uart_data;
    assign wr.busy = busy;                              // imem only takes writes while busy

    // data half, same cycle as the strobe
    assign dmem_wen  = uart_wen & upper_half;
    assign dmem_addr = word_addr;
    assign dmem_data = uart_data;

endmodule

// File: fetch_hazard_ctrl.sv
`timescale 1ns/1ps

module fetch_hazard_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic uart_wen,                              // first strobe starts a load
    input  logic uart_done,                             // pulse after the last word
    input  logic stall,                                 // external back-pressure
    output logic hold,                                  // freeze pc
    output logic no_op,                                 // bubble to decode
    output logic pc_restart,                            // next pc is zero
    output logic busy                                   // loader owns imem
);

    fetch_pkg::load_state_t state_q;
    fetch_pkg::load_state_t state_d;

    logic load_req;                                     // strobe seen while still running

    assign load_req = (state_q == fetch_pkg::LD_RUN) & uart_wen;

    always_comb begin
        state_d = state_q;
        case (state_q)
            fetch_pkg::LD_RUN:     if (uart_wen)  state_d = fetch_pkg::LD_LOAD;
            fetch_pkg::LD_LOAD:    if (uart_done) state_d = fetch_pkg::LD_RESTART;
            fetch_pkg::LD_RESTART: state_d = fetch_pkg::LD_RUN;    // single cycle
            default:               state_d = fetch_pkg::LD_RUN;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= fetch_pkg::LD_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    // The first word arrives while the FSM is still in LD_RUN, so the
    // request already counts as loading. Otherwise that word would be lost.
    assign busy       = (state_q != fetch_pkg::LD_RUN) | load_req;
    assign pc_restart = (state_q == fetch_pkg::LD_RESTART);
    assign hold       = (state_q == fetch_pkg::LD_LOAD)
                      | ((state_q == fetch_pkg::LD_RUN) & (stall | uart_wen));
    assign no_op      = busy | stall;                   // restart cycle is a bubble too

endmodule

// File: fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  uart_wen,             // programmer word strobe
    input  fetch_pkg::load_addr_t uart_addr,
    input  fetch_pkg::word_t      uart_data,
    input  logic                  uart_done,            // end of program stream

    input  logic                  stall,                // hold fetch, emit bubbles
    input  logic                  pc_offset,
    input  fetch_pkg::word_t      pc_offset_value,
    input  logic                  pc_overload,
    input  fetch_pkg::pc_t        pc_overload_value,

    output fetch_pkg::pc_t        pc,
    output fetch_pkg::pc_t        id_pc,
    output fetch_pkg::word_t      instruction,
    output logic                  if_no_op,

    output logic                  dmem_wen,             // data-memory load port
    output fetch_pkg::rom_addr_t  dmem_addr,
    output fetch_pkg::word_t      dmem_data,
    output logic                  loading               // load in progress
);

    logic hold;
    logic no_op;
    logic pc_restart;
    logic busy;

    imem_write_if imem_wr ();                           // loader to imem

    program_loader u_loader (
        .uart_wen  (uart_wen),
        .uart_addr (uart_addr),
        .uart_data (uart_data),
        .busy      (busy),
        .wr        (imem_wr.loader),
        .dmem_wen  (dmem_wen),
        .dmem_addr (dmem_addr),
        .dmem_data (dmem_data)
    );

    fetch_hazard_ctrl u_hazard (
        .clk        (clk),
        .rst_n      (rst_n),
        .uart_wen   (uart_wen),
        .uart_done  (uart_done),
        .stall      (stall),
        .hold       (hold),
        .no_op      (no_op),
        .pc_restart (pc_restart),
        .busy       (busy)
    );

    instruction_fetch u_fetch (
        .clk               (clk),
        .rst_n             (rst_n),
        .hold              (hold),
        .no_op             (no_op),
        .pc_restart        (pc_restart),
        .pc_offset         (pc_offset),
        .pc_offset_value   (pc_offset_value),
        .pc_overload       (pc_overload),
        .pc_overload_value (pc_overload_value),
        .wr                (imem_wr.mem),
        .pc                (pc),
        .id_pc             (id_pc),
        .instruction       (instruction),
        .if_no_op          (if_no_op)
    );

    assign loading = busy;                              // visible to the outside world

endmodule

// File: fetch_assertions.sv
`timescale 1ns/1ps

module fetch_assertions (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  loading,
    input logic                  pc_restart,            // internal restart strobe
    input fetch_pkg::pc_t        pc,
    input logic                  dmem_wen,
    input fetch_pkg::load_addr_t uart_addr,
    input logic                  if_no_op
);

    int fail_count = 0;                                 // polled by the testbench

    // restart cycle is the only loading cycle where pc may move
    pc_frozen_while_loading: assert property (@(posedge clk) disable iff (!rst_n)
        (loading && !pc_restart) |=> $stable(pc))
        else begin
            $error("pc changed while a load was running");
            fail_count++;
        end

    dmem_write_upper_half: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_wen |-> uart_addr[fetch_pkg::ROM_DEPTH])
        else begin
            $error("data-memory write with a lower-half address");
            fail_count++;
        end

    bubble_after_loading: assert property (@(posedge clk) disable iff (!rst_n)
        loading |=> if_no_op)
        else begin
            $error("no bubble in the cycle after loading");
            fail_count++;
        end

endmodule

// File: tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top;

    localparam time CLK_PERIOD   = 100ns;
    localparam int  DMEM_WORDS   = 32;                  // upper-half words per load
    localparam int  LOAD_WORDS   = 2 * (fetch_pkg::ROM_WORDS + DMEM_WORDS + 2);   // two loads
    localparam int  FETCH_CYCLES = 300;                 // reset, fetch, branch and stall phases
    localparam int  STALL_CYCLES = 7;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  uart_wen;
    fetch_pkg::load_addr_t uart_addr;
    fetch_pkg::word_t      uart_data;
    logic                  uart_done;
    logic                  stall;
    logic                  pc_offset;
    fetch_pkg::word_t      pc_offset_value;
    logic                  pc_overload;
    fetch_pkg::pc_t        pc_overload_value;
    fetch_pkg::pc_t        pc;
    fetch_pkg::pc_t        id_pc;
    fetch_pkg::word_t      instruction;
    logic                  if_no_op;
    logic                  dmem_wen;
    fetch_pkg::rom_addr_t  dmem_addr;
    fetch_pkg::word_t      dmem_data;
    logic                  loading;

    fetch_pkg::word_t      model_mem [fetch_pkg::ROM_WORDS];   // mirror of every lower-half write
    fetch_pkg::pc_t        exp_pc;
    fetch_pkg::pc_t        exp_id_pc;
    fetch_pkg::word_t      exp_rom;                     // word the imem read register should hold
    logic                  exp_no_op;
    fetch_pkg::load_state_t exp_state;
    logic [31:0]           lcg_state = 32'h613f_5447;
    string                 test_name = "reset";

    fetch_top uut (.*);

    bind fetch_top fetch_assertions u_assert (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // restart, then overload, then offset, else sequential
    function automatic fetch_pkg::pc_t expected_next_pc(input fetch_pkg::pc_t cur,
            input logic restart, input logic overload, input fetch_pkg::pc_t target,
            input logic offset, input fetch_pkg::word_t delta);
        if (restart) return 32'h0;
        else if (overload) return target;
        else if (offset) return cur + (delta << 2);    // offset counts instructions
        else return cur + 32'd4;
    endfunction

    function automatic fetch_pkg::word_t expected_instruction(input logic bubble,
            input fetch_pkg::word_t word);
        return bubble ? 32'h0 : word;                   // bubble shows all zeros
    endfunction

    task automatic abort_run(input string reason);
        $display("ERROR %s", reason);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check(input string what, input logic [31:0] expected,
            input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s %s expected %h actual %h",
                     test_name, what, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    // full program image with a data word after every 32 instruction words
    task automatic load_program();
        int edges;
        int dmem_idx;
        dmem_idx = 0;
        for (int i = 0; i < fetch_pkg::ROM_WORDS; i++) begin
            @(negedge clk);
            uart_wen  = 1'b1;
            uart_addr = fetch_pkg::load_addr_t'(i);     // msb clear selects the instruction half
            uart_data = next_random();
            if (i % 32 == 31) begin
                @(negedge clk);
                uart_addr = fetch_pkg::load_addr_t'(fetch_pkg::ROM_WORDS + dmem_idx);
                uart_data = next_random();
                dmem_idx++;
            end
        end
        @(negedge clk);
        uart_wen  = 1'b0;
        uart_done = 1'b1;                               // single-cycle pulse
        @(negedge clk);
        uart_done = 1'b0;
        edges     = 1;
        while (loading && edges < 8) begin              // wait for the FSM to let go
            @(negedge clk);
            edges++;
        end
        if (loading) abort_run("loading stayed high after uart_done");
        check("restart edges", 32'd2, edges);
        check("restart pc", 32'h0, pc);
    endtask

    always @(posedge clk) begin : compare_model
        logic             busy_m;
        logic             hold_m;
        fetch_pkg::word_t exp_instr;
        if (!rst_n) begin
            exp_pc    = 32'h0;
            exp_id_pc = 32'h0;
            exp_no_op = 1'b0;
            exp_state = fetch_pkg::LD_RUN;
        end else begin
            busy_m = (exp_state != fetch_pkg::LD_RUN) || uart_wen;     // first word counts
            hold_m = (exp_state == fetch_pkg::LD_LOAD)
                   || ((exp_state == fetch_pkg::LD_RUN) && (stall || uart_wen));
            if (!busy_m) exp_rom = model_mem[exp_pc[fetch_pkg::ROM_DEPTH + 1:2]];
            if (uart_wen && !uart_addr[fetch_pkg::ROM_DEPTH]) begin
                model_mem[uart_addr[fetch_pkg::ROM_DEPTH - 1:0]] = uart_data;
            end
            exp_id_pc = exp_pc;
            exp_no_op = busy_m || stall;
            if (!hold_m) begin
                exp_pc = expected_next_pc(exp_pc, exp_state == fetch_pkg::LD_RESTART,
                                          pc_overload, pc_overload_value,
                                          pc_offset, pc_offset_value);
            end
            case (exp_state)
                fetch_pkg::LD_RUN:  if (uart_wen) exp_state = fetch_pkg::LD_LOAD;
                fetch_pkg::LD_LOAD: if (uart_done) exp_state = fetch_pkg::LD_RESTART;
                default:            exp_state = fetch_pkg::LD_RUN;
            endcase
            #(CLK_PERIOD / 4);                          // outputs settled and inputs not yet moved
            check("pc", exp_pc, pc);
            check("id_pc", exp_id_pc, id_pc);
            check("if_no_op", exp_no_op, if_no_op);
            exp_instr = expected_instruction(exp_no_op, exp_rom);
            if (!$isunknown(exp_instr)) check("instruction", exp_instr, instruction);
            check("loading", (exp_state != fetch_pkg::LD_RUN) || uart_wen, loading);
            check("dmem_wen", uart_wen && uart_addr[fetch_pkg::ROM_DEPTH], dmem_wen);
            if (uart_wen && uart_addr[fetch_pkg::ROM_DEPTH]) begin
                check("dmem_addr", uart_addr[fetch_pkg::ROM_DEPTH - 1:0], dmem_addr);
                check("dmem_data", uart_data, dmem_data);
            end
            if (uut.u_assert.fail_count != 0) abort_run("a concurrent assertion fired");
        end
    end

    initial begin : watchdog
        #((LOAD_WORDS + FETCH_CYCLES + 50) * CLK_PERIOD);
        abort_run("watchdog expired before the test sequence finished");
    end

    initial begin : stimulus
        fetch_pkg::pc_t pc_before;
        logic [31:0]    r;
        rst_n             = 1'b0;
        uart_wen          = 1'b0;
        uart_addr         = '0;
        uart_data         = '0;
        uart_done         = 1'b0;
        stall             = 1'b0;
        pc_offset         = 1'b0;
        pc_offset_value   = '0;
        pc_overload       = 1'b0;
        pc_overload_value = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);                      // fetching from an empty imem

        test_name = "load split";
        load_program();
        test_name = "restart";
        repeat (40) @(negedge clk);

        test_name = "relative branch";
        @(negedge clk);
        pc_before       = pc;
        pc_offset       = 1'b1;
        pc_offset_value = 32'd5;
        @(negedge clk);
        pc_offset = 1'b0;
        check("branch target", pc_before + 32'd20, pc);
        test_name = "branch mix";
        repeat (100) begin
            @(negedge clk);
            r                 = next_random();
            pc_offset         = r[0];
            pc_overload       = r[1];                   // both set on a quarter of the cycles
            pc_offset_value   = {{26{r[9]}}, r[9:4]};   // -32 .. +31 instructions
            pc_overload_value = {20'h0, r[21:12], 2'b00};
        end
        @(negedge clk);
        pc_offset   = 1'b0;
        pc_overload = 1'b0;

        test_name = "stall";
        @(negedge clk);
        pc_before = pc;
        stall     = 1'b1;
        repeat (STALL_CYCLES) begin
            @(negedge clk);
            check("stalled pc", pc_before, pc);
            check("stalled if_no_op", 32'd1, if_no_op);
            check("stalled instruction", 32'h0, instruction);
        end
        stall = 1'b0;
        @(negedge clk);
        check("resume id_pc", pc_before, id_pc);        // fetch picks up at the held pc
        repeat (20) @(negedge clk);

        test_name = "reload";
        load_program();
        repeat (40) @(negedge clk);

        if (uut.u_assert.fail_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("ERROR %0d assertion failures", uut.u_assert.fail_count);
            $display("TEST FAILED");
            $fatal(1, "concurrent assertions failed");
        end
    end

endmodule

// File: fetch.f
fetch_pkg.sv
imem_write_if.sv
instruction_rom.sv
instruction_fetch.sv
program_loader.sv
fetch_hazard_ctrl.sv
fetch_top.sv
fetch_assertions.sv
tb_fetch_top.sv

// File: Bender.yml
package:
  name: fetch

sources:
  - fetch_pkg.sv
  - imem_write_if.sv
  - instruction_rom.sv
  - instruction_fetch.sv
  - program_loader.sv
  - fetch_hazard_ctrl.sv
  - fetch_top.sv
  - target: test
    files:
      - fetch_assertions.sv
      - tb_fetch_top.sv
